// File: Makefile
# Verilator build and run for the video test-pattern source

VERILATOR ?= verilator
TOP       ?= tb_video_pattern
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides the result, the simulator status alone is not trusted
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_video_pattern.sv
`timescale 1ns/1ps

module tb_video_pattern;

  import video_pkg::*;

  localparam int   H_ACTIVE = 64;  // small raster keeps frames short
  localparam int   H_FP     = 4;
  localparam int   H_SYNC   = 6;
  localparam int   H_BP     = 5;
  localparam int   V_ACTIVE = 8;
  localparam int   V_FP     = 2;
  localparam int   V_SYNC   = 3;
  localparam int   V_BP     = 2;
  localparam logic HS_POL   = 1'b1;
  localparam logic VS_POL   = 1'b0;

  localparam int H_TOTAL         = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL         = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
  localparam int BAR_W           = H_ACTIVE / BAR_COUNT;  // pixels per bar
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 10;
  localparam int WATCHDOG_FRAMES = 8;
  localparam int WATCHDOG_NS     = WATCHDOG_FRAMES * FRAME_CYCLES * CLK_PERIOD;

  logic   clk;
  logic   rst;
  logic   hs;
  logic   vs;
  logic   de;
  color_t rgb_r;
  color_t rgb_g;
  color_t rgb_b;
  coord_t pix_y;

  // last two samples of the outputs, taken at the falling edge
  logic   prev_hs;
  logic   prev_vs;
  logic   prev_de;
  logic   cur_hs;
  logic   cur_vs;
  logic   cur_de;
  color_t cur_r;
  color_t cur_g;
  color_t cur_b;
  coord_t cur_y;
  int     cycle;
  int     error_count;

  video_pattern_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP),
    .HS_POL   (HS_POL),
    .VS_POL   (VS_POL)
  ) u_video_pattern_top (
    .clk   (clk),
    .rst   (rst),
    .hs    (hs),
    .vs    (vs),
    .de    (de),
    .rgb_r (rgb_r),
    .rgb_g (rgb_g),
    .rgb_b (rgb_b),
    .pix_y (pix_y)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic hs_lead();
    return (prev_hs != HS_POL) && (cur_hs == HS_POL);
  endfunction

  function automatic logic hs_trail();
    return (prev_hs == HS_POL) && (cur_hs != HS_POL);
  endfunction

  function automatic logic vs_lead();
    return (prev_vs != VS_POL) && (cur_vs == VS_POL);
  endfunction

  function automatic logic vs_trail();
    return (prev_vs == VS_POL) && (cur_vs != VS_POL);
  endfunction

  function automatic logic de_rise();
    return !prev_de && cur_de;
  endfunction

  function automatic logic de_fall();
    return prev_de && !cur_de;
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    error_count++;
    $display("ERR time %0t %s expected %0d got %0d", $time, name, expected, actual);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("error at time %0t: %s", $time, what);
    $display("test failed");
    $fatal(1);
  endtask

  // outputs settle after the rising edge, so look at them half a period later
  task automatic sample_outputs();
    @(negedge clk);
    prev_hs = cur_hs;
    prev_vs = cur_vs;
    prev_de = cur_de;
    cur_hs  = hs;
    cur_vs  = vs;
    cur_de  = de;
    cur_r   = rgb_r;
    cur_g   = rgb_g;
    cur_b   = rgb_b;
    cur_y   = pix_y;
    cycle++;
  endtask

  task automatic check_idle_levels();
    assert (cur_de == 1'b0) else report_mismatch("de", 0, int'(cur_de));
    assert (cur_r == '0) else report_mismatch("rgb_r", 0, int'(cur_r));
    assert (cur_g == '0) else report_mismatch("rgb_g", 0, int'(cur_g));
    assert (cur_b == '0) else report_mismatch("rgb_b", 0, int'(cur_b));
    assert (cur_hs == ~HS_POL) else report_mismatch("hs", int'(~HS_POL), int'(cur_hs));
    assert (cur_vs == ~VS_POL) else report_mismatch("vs", int'(~VS_POL), int'(cur_vs));
  endtask

  // holds rst, then checks a few cycles after release before hs can start
  task automatic check_reset_levels(input int hold_cycles);
    @(posedge clk);
    rst <= 1'b1;
    repeat (hold_cycles) begin
      sample_outputs();
      check_idle_levels();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      sample_outputs();
      check_idle_levels();
    end
  endtask

  task automatic check_horizontal();
    int last_hs  = -1;
    int last_de  = -1;
    int hs_len   = 0;
    int de_len   = 0;
    int hs_count = 0;
    int de_count = 0;
    logic hs_run = 1'b0;
    logic de_run = 1'b0;
    repeat (FRAME_CYCLES) begin
      sample_outputs();
      if (vs_lead()) last_de = -1;  // de spacing only within a frame
      if (hs_lead()) begin
        if (last_hs >= 0) begin
          assert (cycle - last_hs == H_TOTAL)
            else report_mismatch("hs period", H_TOTAL, cycle - last_hs);
        end
        last_hs = cycle;
        hs_len  = 0;
        hs_run  = 1'b1;
        hs_count++;
      end
      if (hs_run && cur_hs == HS_POL) hs_len++;
      if (hs_run && hs_trail()) begin
        assert (hs_len == H_SYNC) else report_mismatch("hs width", H_SYNC, hs_len);
        hs_run = 1'b0;
      end
      if (de_rise()) begin
        if (last_de >= 0) begin
          assert (cycle - last_de == H_TOTAL)
            else report_mismatch("de spacing", H_TOTAL, cycle - last_de);
        end
        last_de = cycle;
        de_len  = 0;
        de_run  = 1'b1;
        de_count++;
      end
      if (de_run && cur_de) de_len++;
      if (de_run && de_fall()) begin
        assert (de_len == H_ACTIVE) else report_mismatch("de width", H_ACTIVE, de_len);
        de_run = 1'b0;
      end
    end
    // one frame length holds one hs pulse per line
    assert (hs_count == V_TOTAL) else report_mismatch("hs pulses", V_TOTAL, hs_count);
    assert (de_count == V_ACTIVE) else report_mismatch("de runs", V_ACTIVE, de_count);
  endtask

  task automatic wait_frame_start();
    while (!vs_lead()) sample_outputs();
  endtask

  task automatic check_vertical();
    int start;
    int de_runs = 0;
    logic trail_seen = 1'b0;
    wait_frame_start();
    assert (hs_lead()) else report_failure("vs leading edge without an hs leading edge");
    start = cycle;
    sample_outputs();
    while (!vs_lead()) begin
      if (vs_trail()) begin
        assert (hs_lead()) else report_failure("vs trailing edge without an hs leading edge");
        assert (cycle - start == V_SYNC * H_TOTAL)
          else report_mismatch("vs width", V_SYNC * H_TOTAL, cycle - start);
        trail_seen = 1'b1;
      end
      if (de_rise()) de_runs++;
      sample_outputs();
    end
    assert (hs_lead()) else report_failure("vs leading edge without an hs leading edge");
    assert (trail_seen) else report_failure("vs never returned to its inactive level");
    assert (cycle - start == FRAME_CYCLES)
      else report_mismatch("vs period", FRAME_CYCLES, cycle - start);
    assert (de_runs == V_ACTIVE) else report_mismatch("de runs", V_ACTIVE, de_runs);
  endtask

  task automatic check_colour_bars();
    int col    = 0;
    int row    = -1;
    int idx;
    int pixels = 0;
    wait_frame_start();
    sample_outputs();
    while (!vs_lead()) begin
      if (de_rise()) begin
        col = 0;
        row++;
      end
      if (cur_de) begin
        idx = col / BAR_W;
        if (idx > BAR_COUNT - 1) idx = BAR_COUNT - 1;
        assert (cur_r == BAR_R[idx]) else report_mismatch("rgb_r", int'(BAR_R[idx]), int'(cur_r));
        assert (cur_g == BAR_G[idx]) else report_mismatch("rgb_g", int'(BAR_G[idx]), int'(cur_g));
        assert (cur_b == BAR_B[idx]) else report_mismatch("rgb_b", int'(BAR_B[idx]), int'(cur_b));
        if (idx == 0) begin
          assert ((cur_r & cur_g & cur_b) == 8'hff)
            else report_failure("first bar is not white");
        end
        if (idx == BAR_COUNT - 1) begin
          assert ((cur_r | cur_g | cur_b) == 8'h00)
            else report_failure("last bar is not black");
        end
        assert (cur_y == coord_t'(row)) else report_mismatch("pix_y", row, int'(cur_y));
        col++;
        pixels++;
      end
      sample_outputs();
    end
    assert (pixels == H_ACTIVE * V_ACTIVE)
      else report_mismatch("active pixels", H_ACTIVE * V_ACTIVE, pixels);
  endtask

  // any window of one frame length holds the same number of de cycles
  task automatic check_blanking();
    int active = 0;
    repeat (FRAME_CYCLES) begin
      sample_outputs();
      if (cur_de) begin
        active++;
      end else begin
        assert (cur_r == '0) else report_mismatch("rgb_r", 0, int'(cur_r));
        assert (cur_g == '0) else report_mismatch("rgb_g", 0, int'(cur_g));
        assert (cur_b == '0) else report_mismatch("rgb_b", 0, int'(cur_b));
      end
    end
    assert (active == H_ACTIVE * V_ACTIVE)
      else report_mismatch("de cycles", H_ACTIVE * V_ACTIVE, active);
  endtask

  task automatic check_mid_frame_reset();
    while (!de_rise()) sample_outputs();
    repeat (20) begin  // land well inside the line
      sample_outputs();
      assert (cur_de) else report_failure("active line ended before the reset point");
    end
    check_reset_levels(RESET_CYCLES);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d frame times", WATCHDOG_FRAMES);
    $display("test failed");
    $fatal(1);
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    prev_hs     = ~HS_POL;
    prev_vs     = ~VS_POL;
    prev_de     = 1'b0;
    cur_hs      = ~HS_POL;
    cur_vs      = ~VS_POL;
    cur_de      = 1'b0;
    cur_r       = '0;
    cur_g       = '0;
    cur_b       = '0;
    cur_y       = '0;
    cycle       = 0;
    error_count = 0;

    check_reset_levels(RESET_CYCLES);
    check_horizontal();
    check_blanking();
    check_colour_bars();
    check_vertical();
    check_mid_frame_reset();
    check_horizontal();
    check_colour_bars();

    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: hw/color_bar_gen.sv
`timescale 1ns/1ps

module color_bar_gen #(
  parameter int   H_ACTIVE = 640,   // sets the bar width
  parameter logic HS_POL   = 1'b0,  // active level of hs
  parameter logic VS_POL   = 1'b0   // active level of vs
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              raw_hs,
  input  logic              raw_vs,
  input  logic              raw_de,
  input  video_pkg::coord_t pix_x,
  output logic              hs,
  output logic              vs,
  output logic              de,
  output video_pkg::color_t rgb_r,
  output video_pkg::color_t rgb_g,
  output video_pkg::color_t rgb_b
);

  import video_pkg::*;

  // narrow rasters still get a usable width of one pixel
  localparam int BAR_W     = (H_ACTIVE / BAR_COUNT > 0) ? H_ACTIVE / BAR_COUNT : 1;
  localparam int BAR_IDX_W = $clog2(BAR_COUNT);
  localparam int BAR_MAX   = BAR_COUNT - 1;

  coord_t               bar_quot;  // raw column / width
  logic [BAR_IDX_W-1:0] bar_idx;
  color_t               pix_r;
  color_t               pix_g;
  color_t               pix_b;

  assign bar_quot = pix_x / coord_t'(BAR_W);

  // leftover columns past the last full bar stay in the black bar
  assign bar_idx = (bar_quot > coord_t'(BAR_MAX)) ? BAR_IDX_W'(BAR_MAX)
                                                  : bar_quot[BAR_IDX_W-1:0];

  // blank outside the active window
  assign pix_r = raw_de ? BAR_R[bar_idx] : '0;
  assign pix_g = raw_de ? BAR_G[bar_idx] : '0;
  assign pix_b = raw_de ? BAR_B[bar_idx] : '0;

  // one stage for everything so hs, vs, de and rgb stay aligned
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hs    <= ~HS_POL;  // inactive level
      vs    <= ~VS_POL;
      de    <= 1'b0;
      rgb_r <= '0;
      rgb_g <= '0;
      rgb_b <= '0;
    end else begin
      hs    <= raw_hs;
      vs    <= raw_vs;
      de    <= raw_de;
      rgb_r <= pix_r;
      rgb_g <= pix_g;
      rgb_b <= pix_b;
    end
  end

endmodule

// File: hw/video_pattern_top.sv
`timescale 1ns/1ps

module video_pattern_top #(
  parameter int   H_ACTIVE = 640,   // 640x480 at 60 Hz by default
  parameter int   H_FP     = 16,
  parameter int   H_SYNC   = 96,
  parameter int   H_BP     = 48,
  parameter int   V_ACTIVE = 480,
  parameter int   V_FP     = 10,
  parameter int   V_SYNC   = 2,
  parameter int   V_BP     = 33,
  parameter logic HS_POL   = 1'b0,  // negative syncs
  parameter logic VS_POL   = 1'b0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              hs,
  output logic              vs,
  output logic              de,
  output video_pkg::color_t rgb_r,
  output video_pkg::color_t rgb_g,
  output video_pkg::color_t rgb_b,
  output video_pkg::coord_t pix_y  // debug, line within active area
);

  import video_pkg::*;

  logic   raw_hs;
  logic   raw_vs;
  logic   raw_de;
  coord_t pix_x;

  video_timing_gen #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP),
    .HS_POL   (HS_POL),
    .VS_POL   (VS_POL)
  ) u_timing (
    .clk    (clk),
    .rst    (rst),
    .raw_hs (raw_hs),
    .raw_vs (raw_vs),
    .raw_de (raw_de),
    .pix_x  (pix_x),
    .pix_y  (pix_y)
  );

  color_bar_gen #(
    .H_ACTIVE (H_ACTIVE),
    .HS_POL   (HS_POL),
    .VS_POL   (VS_POL)
  ) u_bars (
    .clk    (clk),
    .rst    (rst),
    .raw_hs (raw_hs),
    .raw_vs (raw_vs),
    .raw_de (raw_de),
    .pix_x  (pix_x),
    .hs     (hs),
    .vs     (vs),
    .de     (de),
    .rgb_r  (rgb_r),
    .rgb_g  (rgb_g),
    .rgb_b  (rgb_b)
  );

endmodule

// File: hw/video_pkg.sv
package video_pkg;

  localparam int COORD_W = 12;  // totals up to 4095
  localparam int COLOR_W = 8;   // one component per channel

  // pixel or line position, also used for the raster counters
  typedef logic [COORD_W-1:0] coord_t;

  // single colour component
  typedef logic [COLOR_W-1:0] color_t;

  localparam int BAR_COUNT = 8;

  // bar palette, index 0 is the leftmost bar
  localparam color_t BAR_R [BAR_COUNT] = '{
    8'hff,  // white
    8'hff,  // yellow
    8'h00,  // cyan
    8'h00,  // green
    8'hff,  // magenta
    8'hff,  // red
    8'h00,  // blue
    8'h00   // black
  };

  localparam color_t BAR_G [BAR_COUNT] = '{
    8'hff,  // white
    8'hff,  // yellow
    8'hff,  // cyan
    8'hff,  // green
    8'h00,  // magenta
    8'h00,  // red
    8'h00,  // blue
    8'h00   // black
  };

  localparam color_t BAR_B [BAR_COUNT] = '{
    8'hff,  // white
    8'h00,  // yellow
    8'hff,  // cyan
    8'h00,  // green
    8'hff,  // magenta
    8'h00,  // red
    8'hff,  // blue
    8'h00   // black
  };

endpackage

// File: hw/video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen #(
  parameter int   H_ACTIVE = 640,   // pixels
  parameter int   H_FP     = 16,
  parameter int   H_SYNC   = 96,
  parameter int   H_BP     = 48,
  parameter int   V_ACTIVE = 480,   // lines
  parameter int   V_FP     = 10,
  parameter int   V_SYNC   = 2,
  parameter int   V_BP     = 33,
  parameter logic HS_POL   = 1'b0,  // active level of hs
  parameter logic VS_POL   = 1'b0   // active level of vs
) (
  input  logic              clk,
  input  logic              rst,
  output logic              raw_hs,
  output logic              raw_vs,
  output logic              raw_de,
  output video_pkg::coord_t pix_x,
  output video_pkg::coord_t pix_y
);

  import video_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  // phase boundaries, counted from the start of the front porch
  localparam coord_t H_SYNC_START = coord_t'(H_FP);
  localparam coord_t H_SYNC_END   = coord_t'(H_FP + H_SYNC);
  localparam coord_t H_ACT_START  = coord_t'(H_FP + H_SYNC + H_BP);
  localparam coord_t H_LAST       = coord_t'(H_TOTAL - 1);

  localparam coord_t V_SYNC_START = coord_t'(V_FP);
  localparam coord_t V_SYNC_END   = coord_t'(V_FP + V_SYNC);
  localparam coord_t V_ACT_START  = coord_t'(V_FP + V_SYNC + V_BP);
  localparam coord_t V_LAST       = coord_t'(V_TOTAL - 1);

  // the line advances on the pixel just before hsync starts,
  // wrapping to the end of the line when there is no front porch
  localparam coord_t LINE_STEP_AT = (H_FP > 0) ? coord_t'(H_FP - 1) : H_LAST;

  coord_t h_cnt;      // pixel within the line
  coord_t v_cnt;      // line within the frame
  logic   h_last;     // last pixel of the line
  logic   line_step;  // vertical counter moves on
  logic   h_in_sync;
  logic   h_in_act;
  logic   v_in_sync;
  logic   v_in_act;

  assign h_last    = (h_cnt == H_LAST);
  assign line_step = (h_cnt == LINE_STEP_AT);

  assign h_in_sync = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
  assign h_in_act  = (h_cnt >= H_ACT_START);  // active is the tail of the line
  assign v_in_sync = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
  assign v_in_act  = (v_cnt >= V_ACT_START);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      h_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + coord_t'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v_cnt <= '0;
    end else if (line_step) begin
      if (v_cnt == V_LAST) begin
        v_cnt <= '0;  // frame wrap
      end else begin
        v_cnt <= v_cnt + coord_t'(1);
      end
    end
  end

  // registered flags, one cycle behind the counters
  // v_cnt moved one cycle before hsync, so vs and de edges
  // land on the same cycle as the hs leading edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      raw_hs <= ~HS_POL;
      raw_vs <= ~VS_POL;
      raw_de <= 1'b0;
    end else begin
      raw_hs <= h_in_sync ? HS_POL : ~HS_POL;
      raw_vs <= v_in_sync ? VS_POL : ~VS_POL;
      raw_de <= h_in_act & v_in_act;
    end
  end

  // coordinates only meaningful inside the active window
  always_ff @(posedge clk) begin
    pix_x <= h_cnt - H_ACT_START;
    pix_y <= v_cnt - V_ACT_START;
  end

endmodule

// File: project.f
hw/video_pkg.sv
hw/video_timing_gen.sv
hw/color_bar_gen.sv
hw/video_pattern_top.sv
bench/tb_video_pattern.sv
